/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  rv32i_pkg::alu_op_t op,
    input  rv32i_pkg::rv_word  a,
    input  rv32i_pkg::rv_word  b,
    output rv32i_pkg::rv_word  f,
    output logic               br_en
);

    logic lt;
    logic ltu;

    assign lt = $signed(a) < $signed(b);
    assign ltu = a < b;

    // branch flag only from the compare ops
    always_comb begin
        case (op)
            rv32i_pkg::alu_eq:  br_en = (a == b);
            rv32i_pkg::alu_ne:  br_en = (a != b);
            rv32i_pkg::alu_lt:  br_en = lt;
            rv32i_pkg::alu_ltu: br_en = ltu;
            default:            br_en = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            rv32i_pkg::alu_add:  f = a + b;
            rv32i_pkg::alu_sub:  f = a - b;
            rv32i_pkg::alu_and:  f = a & b;
            rv32i_pkg::alu_or:   f = a | b;
            rv32i_pkg::alu_xor:  f = a ^ b;
            rv32i_pkg::alu_slt:  f = rv32i_pkg::rv_word'(lt);
            rv32i_pkg::alu_sltu: f = rv32i_pkg::rv_word'(ltu);
            rv32i_pkg::alu_sll:  f = a << b[4:0];
            rv32i_pkg::alu_srl:  f = a >> b[4:0];
            rv32i_pkg::alu_sra:  f = $signed(a) >>> b[4:0];
            default:             f = rv32i_pkg::rv_word'(br_en);
        endcase
    end

endmodule

/* hw/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  rv32i_pkg::rv_word     instr,
    output rv32i_pkg::ctrl_word_t ctrl
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        ctrl = '0;
        ctrl.instr = instr;
        ctrl.dest = instr[11:7];
        legal = 1'b1;
        case (rv32i_pkg::rv_opcode'(instr[6:0]))
            rv32i_pkg::op_reg: begin
                ctrl.load_regfile = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = funct7[5] ? rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
                    3'b001: ctrl.alu_op = rv32i_pkg::alu_sll;
                    3'b010: ctrl.alu_op = rv32i_pkg::alu_slt;
                    3'b011: ctrl.alu_op = rv32i_pkg::alu_sltu;
                    3'b100: ctrl.alu_op = rv32i_pkg::alu_xor;
                    3'b101: ctrl.alu_op = funct7[5] ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
                    3'b110: ctrl.alu_op = rv32i_pkg::alu_or;
                    default: ctrl.alu_op = rv32i_pkg::alu_and;
                endcase
            end
            rv32i_pkg::op_imm: begin
                // only addi of the immediate group
                legal = (funct3 == 3'b000);
                ctrl.alu_b_sel = rv32i_pkg::b_i_imm;
                ctrl.load_regfile = 1'b1;
            end
            rv32i_pkg::op_lui: begin
                ctrl.wb_sel = rv32i_pkg::wb_uimm;
                ctrl.load_regfile = 1'b1;
            end
            rv32i_pkg::op_br: begin
                legal = (funct3 == 3'b000) || (funct3 == 3'b001);
                ctrl.alu_op = funct3[0] ? rv32i_pkg::alu_ne : rv32i_pkg::alu_eq;
                ctrl.branch = rv32i_pkg::br_cond;
            end
            rv32i_pkg::op_jal: begin
                // alu computes the jump target, link comes from pc + 4
                ctrl.alu_a_sel = rv32i_pkg::a_pc;
                ctrl.alu_b_sel = rv32i_pkg::b_j_imm;
                ctrl.wb_sel = rv32i_pkg::wb_pc4;
                ctrl.branch = rv32i_pkg::br_jump;
                ctrl.load_regfile = 1'b1;
            end
            rv32i_pkg::op_load: begin
                legal = (funct3 == 3'b000) || (funct3 == 3'b010) || (funct3 == 3'b100);
                ctrl.alu_b_sel = rv32i_pkg::b_i_imm;
                ctrl.mem_read = 1'b1;
                ctrl.mem_byte = (funct3 != 3'b010);
                ctrl.load_regfile = 1'b1;
                case (funct3)
                    3'b000: ctrl.wb_sel = rv32i_pkg::wb_lb;
                    3'b100: ctrl.wb_sel = rv32i_pkg::wb_lbu;
                    default: ctrl.wb_sel = rv32i_pkg::wb_lw;
                endcase
            end
            rv32i_pkg::op_store: begin
                legal = (funct3 == 3'b000) || (funct3 == 3'b010);
                ctrl.alu_b_sel = rv32i_pkg::b_s_imm;
                ctrl.mem_write = 1'b1;
                ctrl.mem_byte = (funct3 == 3'b000);
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            ctrl = '0;
        end
    end

endmodule

/* hw/datapath.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module datapath (
    input  logic                  clk,
    input  logic                  rst,
    output mem_bus_pkg::mem_req_t inst_req,
    output logic                  inst_valid,
    input  logic                  inst_ready,
    input  logic                  inst_rsp_valid,
    output mem_bus_pkg::mem_req_t data_req,
    output logic                  data_valid,
    input  logic                  data_ready,
    input  logic                  data_rsp_valid,
    input  rv32i_pkg::rv_word     rsp_rdata
);

    // step handshake
    logic run, inst_sent, inst_done, data_sent, data_done;
    logic data_access, advance, taken;
    rv32i_pkg::rv_word inst_buf, data_buf, target;

    // IF and IF/ID
    rv32i_pkg::rv_word pc, pc_id, ir_id;
    rv32i_pkg::ctrl_word_t ctrl_id;
    rv32i_pkg::rv_word reg_a, reg_b;

    // ID/EX
    rv32i_pkg::ctrl_word_t ctrl_ex;
    rv32i_pkg::rv_word pc_ex, rs1_ex, rs2_ex;
    rv32i_pkg::rv_word i_imm, s_imm, b_imm, j_imm;
    rv32i_pkg::rv_word alu_a, alu_b, alu_f;
    logic br_en;

    // EX/MEM
    rv32i_pkg::ctrl_word_t ctrl_mem;
    rv32i_pkg::rv_word pc_mem, alu_mem, rs2_mem, br_target_mem;
    logic br_en_mem;
    logic [1:0] lane_mem;

    // MEM/WB
    rv32i_pkg::ctrl_word_t ctrl_wb;
    rv32i_pkg::rv_word pc_wb, alu_wb, data_wb, wb_data;
    logic [7:0] ld_byte;

    assign data_access = ctrl_mem.mem_read | ctrl_mem.mem_write;
    assign advance = inst_done & (data_done | ~data_access);
    assign inst_valid = run & ~inst_sent;
    assign data_valid = data_access & ~data_sent;

    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
            inst_sent <= 1'b0;
            inst_done <= 1'b0;
            data_sent <= 1'b0;
            data_done <= 1'b0;
        end else begin
            run <= 1'b1;
            if (advance) begin
                inst_sent <= 1'b0;
                inst_done <= 1'b0;
                data_sent <= 1'b0;
                data_done <= 1'b0;
            end else begin
                inst_sent <= inst_sent | (inst_valid & inst_ready);
                inst_done <= inst_done | inst_rsp_valid;
                data_sent <= data_sent | (data_valid & data_ready);
                data_done <= data_done | data_rsp_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_rsp_valid) begin
            inst_buf <= rsp_rdata;
        end
        if (data_rsp_valid) begin
            data_buf <= rsp_rdata;
        end
    end

    // fetch is always a full word read at pc
    assign inst_req = '{addr: pc, wdata: '0, write: 1'b0, mask: 4'hf};

    // taken branch or jal in MEM redirects the pc
    assign taken = (ctrl_mem.branch == rv32i_pkg::br_jump) |
                   ((ctrl_mem.branch == rv32i_pkg::br_cond) & br_en_mem);
    assign target = (ctrl_mem.branch == rv32i_pkg::br_jump) ? alu_mem : br_target_mem;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
            ir_id <= '0;
            ctrl_ex <= '0;
            ctrl_mem <= '0;
            ctrl_wb <= '0;
        end else if (advance) begin
            pc <= taken ? target : pc + 32'd4;
            // flush turns the three younger stages into bubbles
            ir_id <= taken ? '0 : inst_buf;
            ctrl_ex <= taken ? '0 : ctrl_id;
            ctrl_mem <= taken ? '0 : ctrl_ex;
            ctrl_wb <= ctrl_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pc_id <= pc;
            pc_ex <= pc_id;
            rs1_ex <= reg_a;
            rs2_ex <= reg_b;
            pc_mem <= pc_ex;
            alu_mem <= alu_f;
            br_en_mem <= br_en;
            br_target_mem <= pc_ex + b_imm;
            rs2_mem <= rs2_ex;
            pc_wb <= pc_mem;
            alu_wb <= alu_mem;
            data_wb <= data_buf;
        end
    end

    control_unit u_control (
        .instr (ir_id),
        .ctrl  (ctrl_id)
    );

    // written at the advance edge
    regfile u_regfile (
        .clk   (clk),
        .rst   (rst),
        .load  (ctrl_wb.load_regfile & advance),
        .wdata (wb_data),
        .src_a (ir_id[19:15]),
        .src_b (ir_id[24:20]),
        .dest  (ctrl_wb.dest),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    assign i_imm = {{21{ctrl_ex.instr[31]}}, ctrl_ex.instr[30:20]};
    assign s_imm = {{21{ctrl_ex.instr[31]}}, ctrl_ex.instr[30:25], ctrl_ex.instr[11:7]};
    assign b_imm = {{20{ctrl_ex.instr[31]}}, ctrl_ex.instr[7], ctrl_ex.instr[30:25],
                    ctrl_ex.instr[11:8], 1'b0};
    assign j_imm = {{12{ctrl_ex.instr[31]}}, ctrl_ex.instr[19:12], ctrl_ex.instr[20],
                    ctrl_ex.instr[30:21], 1'b0};

    assign alu_a = (ctrl_ex.alu_a_sel == rv32i_pkg::a_pc) ? pc_ex : rs1_ex;

    always_comb begin
        case (ctrl_ex.alu_b_sel)
            rv32i_pkg::b_i_imm: alu_b = i_imm;
            rv32i_pkg::b_s_imm: alu_b = s_imm;
            rv32i_pkg::b_j_imm: alu_b = j_imm;
            default:            alu_b = rs2_ex;
        endcase
    end

    alu u_alu (
        .op    (ctrl_ex.alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_f),
        .br_en (br_en)
    );

    // byte stores replicate the byte on all lanes, the mask picks one
    assign lane_mem = alu_mem[1:0];

    always_comb begin
        data_req.addr = {alu_mem[31:2], 2'b00};
        data_req.write = ctrl_mem.mem_write;
        if (ctrl_mem.mem_byte) begin
            data_req.mask = 4'b0001 << lane_mem;
            data_req.wdata = {4{rs2_mem[7:0]}};
        end else begin
            data_req.mask = 4'hf;
            data_req.wdata = rs2_mem;
        end
    end

    assign ld_byte = data_wb[8*alu_wb[1:0] +: 8];

    always_comb begin
        case (ctrl_wb.wb_sel)
            rv32i_pkg::wb_lw:   wb_data = data_wb;
            rv32i_pkg::wb_lb:   wb_data = {{24{ld_byte[7]}}, ld_byte};
            rv32i_pkg::wb_lbu:  wb_data = {24'b0, ld_byte};
            rv32i_pkg::wb_pc4:  wb_data = pc_wb + 32'd4;
            rv32i_pkg::wb_uimm: wb_data = {ctrl_wb.instr[31:12], 12'b0};
            default:            wb_data = alu_wb;
        endcase
    end

endmodule

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_bus_pkg::mem_req_t inst_req,
    input  logic                  inst_valid,
    output logic                  inst_ready,
    output logic                  inst_rsp_valid,
    input  mem_bus_pkg::mem_req_t data_req,
    input  logic                  data_valid,
    output logic                  data_ready,
    output logic                  data_rsp_valid,
    output mem_bus_pkg::mem_req_t mem_req,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid
);

    mem_bus_pkg::arb_state_t state;
    mem_bus_pkg::requester_t owner;
    mem_bus_pkg::requester_t sel;

    // data first, nothing new while a request is outstanding
    always_comb begin
        sel = mem_bus_pkg::req_none;
        if (state == mem_bus_pkg::arb_idle) begin
            if (data_valid) begin
                sel = mem_bus_pkg::req_data;
            end else if (inst_valid) begin
                sel = mem_bus_pkg::req_inst;
            end
        end
    end

    assign mem_req = (sel == mem_bus_pkg::req_inst) ? inst_req : data_req;
    assign mem_req_valid = (sel != mem_bus_pkg::req_none);
    assign inst_ready = (sel == mem_bus_pkg::req_inst) & mem_req_ready;
    assign data_ready = (sel == mem_bus_pkg::req_data) & mem_req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_bus_pkg::arb_idle;
            owner <= mem_bus_pkg::req_none;
        end else if (state == mem_bus_pkg::arb_idle) begin
            if (mem_req_valid && mem_req_ready) begin
                state <= mem_bus_pkg::arb_busy;
                owner <= sel;
            end
        end else if (mem_rsp_valid) begin
            state <= mem_bus_pkg::arb_idle;
            owner <= mem_bus_pkg::req_none;
        end
    end

    // response goes back to whoever was granted
    assign inst_rsp_valid = mem_rsp_valid & (state == mem_bus_pkg::arb_busy) &
                            (owner == mem_bus_pkg::req_inst);
    assign data_rsp_valid = mem_rsp_valid & (state == mem_bus_pkg::arb_busy) &
                            (owner == mem_bus_pkg::req_data);

endmodule

/* hw/mem_bus_pkg.sv */
package mem_bus_pkg;

    // one bit per byte lane of a word
    typedef logic [3:0] byte_mask_t;

    // request as seen on each channel and on the memory port
    typedef struct packed {
        rv32i_pkg::rv_word addr;
        rv32i_pkg::rv_word wdata;
        logic              write;
        byte_mask_t        mask;
    } mem_req_t;

    // who owns the outstanding request
    typedef enum logic [1:0] {
        req_none,
        req_inst,
        req_data
    } requester_t;

    typedef enum logic {
        arb_idle,
        arb_busy
    } arb_state_t;

endpackage

/* hw/regfile.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module regfile (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  rv32i_pkg::rv_word wdata,
    input  rv32i_pkg::reg_idx src_a,
    input  rv32i_pkg::reg_idx src_b,
    input  rv32i_pkg::reg_idx dest,
    output rv32i_pkg::rv_word reg_a,
    output rv32i_pkg::rv_word reg_b
);

    rv32i_pkg::rv_word regs [`RV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (load && (dest != '0)) begin
            regs[dest] <= wdata;
        end
    end

    // write-through so WB and ID can share a step
    assign reg_a = (load && (dest != '0) && (dest == src_a)) ? wdata : regs[src_a];
    assign reg_b = (load && (dest != '0) && (dest == src_b)) ? wdata : regs[src_b];

endmodule

/* hw/rv32i_pkg.sv */
`include "rv_core_cfg.svh"

package rv32i_pkg;

    // one data word or address
    typedef logic [`RV_XLEN-1:0] rv_word;

    // register number from rs1, rs2 or rd
    typedef logic [4:0] reg_idx;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_br    = 7'b1100011,
        op_jal   = 7'b1101111,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } rv_opcode;

    // eq, ne, lt and ltu also drive the branch flag
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_eq,
        alu_ne,
        alu_lt,
        alu_ltu
    } alu_op_t;

    typedef enum logic {a_rs1, a_pc} alu_a_sel_t;

    typedef enum logic [1:0] {b_rs2, b_i_imm, b_s_imm, b_j_imm} alu_b_sel_t;

    // register writeback source
    typedef enum logic [2:0] {wb_alu, wb_lw, wb_lb, wb_lbu, wb_pc4, wb_uimm} wb_sel_t;

    typedef enum logic [1:0] {br_none, br_cond, br_jump} br_kind_t;

    // all-zero value of this struct is a bubble
    typedef struct packed {
        alu_op_t    alu_op;
        alu_a_sel_t alu_a_sel;
        alu_b_sel_t alu_b_sel;
        wb_sel_t    wb_sel;
        logic       mem_read;
        logic       mem_write;
        logic       mem_byte;
        logic       load_regfile;
        reg_idx     dest;
        br_kind_t   branch;
        rv_word     instr;
    } ctrl_word_t;

endpackage

/* hw/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
    input  logic                  clk,
    input  logic                  rst,
    output mem_bus_pkg::mem_req_t mem_req,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  rv32i_pkg::rv_word     mem_rsp_rdata
);

    mem_bus_pkg::mem_req_t inst_req;
    mem_bus_pkg::mem_req_t data_req;
    logic inst_valid, inst_ready, inst_rsp_valid;
    logic data_valid, data_ready, data_rsp_valid;

    datapath u_datapath (
        .clk            (clk),
        .rst            (rst),
        .inst_req       (inst_req),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst_rsp_valid (inst_rsp_valid),
        .data_req       (data_req),
        .data_valid     (data_valid),
        .data_ready     (data_ready),
        .data_rsp_valid (data_rsp_valid),
        .rsp_rdata      (mem_rsp_rdata)
    );

    mem_arbiter u_arbiter (
        .clk            (clk),
        .rst            (rst),
        .inst_req       (inst_req),
        .inst_valid     (inst_valid),
        .inst_ready     (inst_ready),
        .inst_rsp_valid (inst_rsp_valid),
        .data_req       (data_req),
        .data_valid     (data_valid),
        .data_ready     (data_ready),
        .data_rsp_valid (data_rsp_valid),
        .mem_req        (mem_req),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid)
    );

endmodule

/* include/rv_core_cfg.svh */
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// core configuration shared by packages and RTL

// data word width in bits
`define RV_XLEN 32

// address of the first fetch after reset
`define RV_RESET_PC 32'h0000_0000

// architectural integer registers, x0 included
`define RV_NUM_REGS 32

`endif

/* list.f */
+incdir+include
hw/rv32i_pkg.sv
hw/mem_bus_pkg.sv
hw/control_unit.sv
hw/alu.sv
hw/regfile.sv
hw/datapath.sv
hw/mem_arbiter.sv
hw/rv_core_top.sv
tb/rv_core_checker.sv
tb/rv_core_tb.sv

/* tb/rv_core_checker.sv */
`timescale 1ns/1ps

module rv_core_checker (
    input logic                  clk,
    input logic                  rst,
    input mem_bus_pkg::mem_req_t inst_req,
    input logic                  inst_valid,
    input logic                  inst_ready,
    input logic                  inst_rsp_valid,
    input mem_bus_pkg::mem_req_t data_req,
    input logic                  data_valid,
    input logic                  data_ready,
    input logic                  data_rsp_valid,
    input logic                  mem_req_valid,
    input logic                  mem_req_ready,
    input logic                  mem_rsp_valid
);

    // sticky, raised by any failing property
    logic violated = 1'b0;

    // a stalled request keeps its fields
    inst_held: assert property (@(posedge clk) disable iff (rst)
        inst_valid && !inst_ready |=> $stable(inst_req))
        else begin
            $error("fetch request changed while stalled");
            violated = 1'b1;
        end

    data_held: assert property (@(posedge clk) disable iff (rst)
        data_valid && !data_ready |=> $stable(data_req))
        else begin
            $error("data request changed while stalled");
            violated = 1'b1;
        end

    // memory answers next cycle, so no new request may show then
    one_outstanding: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && mem_req_ready |=> !mem_req_valid)
        else begin
            $error("second request while one is outstanding");
            violated = 1'b1;
        end

    // routed strobe only for the channel that was granted
    inst_rsp_granted: assert property (@(posedge clk) disable iff (rst)
        inst_rsp_valid |-> $past(inst_valid && inst_ready))
        else begin
            $error("fetch response without a granted fetch");
            violated = 1'b1;
        end

    data_rsp_granted: assert property (@(posedge clk) disable iff (rst)
        data_rsp_valid |-> $past(data_valid && data_ready))
        else begin
            $error("data response without a granted data request");
            violated = 1'b1;
        end

    // every memory response reaches its owner
    rsp_routed: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> inst_rsp_valid || data_rsp_valid)
        else begin
            $error("memory response not routed to any channel");
            violated = 1'b1;
        end

endmodule

bind mem_arbiter rv_core_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .inst_req       (inst_req),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .inst_rsp_valid (inst_rsp_valid),
    .data_req       (data_req),
    .data_valid     (data_valid),
    .data_ready     (data_ready),
    .data_rsp_valid (data_rsp_valid),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_rsp_valid  (mem_rsp_valid)
);

/* tb/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_tb;

    localparam int NROWS = 72;
    localparam int BLOCK = 12;
    localparam int DATA_BASE = 32'h4000;
    localparam int LIMIT = NROWS * BLOCK * 8;
    localparam logic [31:0] NOP = 32'h0000_0013;

    typedef enum int {
        t_add, t_sub, t_and, t_or, t_xor, t_slt, t_sltu, t_sll, t_srl, t_sra,
        t_addi, t_lui, t_beq, t_bne, t_jal, t_lb, t_lbu, t_sb
    } tb_op_t;

    logic clk = 1'b0;
    logic rst;
    mem_bus_pkg::mem_req_t mem_req;
    logic mem_req_valid, mem_req_ready, mem_rsp_valid;
    logic [31:0] mem_rsp_rdata;

    logic [31:0] rng = 32'he975;
    logic [31:0] mem [int unsigned];
    tb_op_t row_op [NROWS];
    logic [31:0] row_a [NROWS];
    logic [31:0] row_b [NROWS];
    logic [31:0] row_exp [NROWS];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0] exp_mask [$];
    logic rsp_pending = 1'b0;
    logic first_seen = 1'b0;
    logic [31:0] rsp_word;
    int cycles = 0;

    rv_core_top dut (
        .clk           (clk),
        .rst           (rst),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_rdata (mem_rsp_rdata)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // RV32I result rule per operation; branches give the taken flag
    function automatic logic [31:0] expected_result(tb_op_t op, logic [31:0] a, logic [31:0] b);
        logic [31:0] w;
        logic [7:0] by;
        by = a[8*b[1:0] +: 8];
        w = a;
        w[8*b[9:8] +: 8] = b[7:0];
        case (op)
            t_add:  return a + b;
            t_sub:  return a - b;
            t_and:  return a & b;
            t_or:   return a | b;
            t_xor:  return a ^ b;
            t_slt:  return {31'b0, $signed(a) < $signed(b)};
            t_sltu: return {31'b0, a < b};
            t_sll:  return a << b[4:0];
            t_srl:  return a >> b[4:0];
            t_sra:  return $signed(a) >>> b[4:0];
            t_addi: return a + {{20{b[11]}}, b[11:0]};
            t_lui:  return {b[19:0], 12'b0};
            t_beq:  return {31'b0, a == b};
            t_bne:  return {31'b0, a != b};
            t_jal:  return a + 32'd4;
            t_lb:   return {{24{by[7]}}, by};
            t_lbu:  return {24'b0, by};
            default: return w;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // stores are always based on x4
    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
        return {imm[11:5], rs2, 5'd4, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] lane_bits(logic [3:0] mask);
        return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    endfunction

    task automatic expect_store(logic [31:0] addr, logic [3:0] mask, logic [31:0] data);
        exp_addr.push_back(addr);
        exp_mask.push_back(mask);
        exp_data.push_back(data);
    endtask

    task automatic fail_now();
        $display("sim failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic verify_handshake();
        assert (!dut.u_arbiter.u_checker.violated) else begin
            $display("memory handshake property failed before %0t", $time);
            fail_now();
        end
    endtask

    task automatic fill_table();
        int pass;
        for (int i = 0; i < NROWS; i++) begin
            pass = i / 18;
            row_op[i] = tb_op_t'(i % 18);
            row_a[i] = xorshift();
            row_b[i] = xorshift();
            // odd passes get equal operands so each branch goes both ways
            if (pass[0] && (row_op[i] == t_beq || row_op[i] == t_bne)) begin
                row_b[i] = row_a[i];
            end
            // one pass per byte lane for the byte loads and the byte store
            if (row_op[i] == t_lb || row_op[i] == t_lbu) begin
                row_b[i][1:0] = pass[1:0];
            end
            if (row_op[i] == t_sb) begin
                row_b[i][9:8] = pass[1:0];
            end
            if (row_op[i] == t_jal) begin
                row_a[i] = 16 + i * BLOCK * 4 + 20;
            end
            row_exp[i] = expected_result(row_op[i], row_a[i], row_b[i]);
        end
    endtask

    task automatic build_program();
        logic [31:0] w [BLOCK];
        int base;
        int d;
        int r;
        mem[0] = {20'h4, 5'd4, 7'b0110111};
        for (int k = 1; k < 4; k++) begin
            mem[k] = NOP;
        end
        for (int i = 0; i < NROWS; i++) begin
            base = 16 + i * BLOCK * 4;
            d = i * 8;
            r = 32'h400 + i * 8;
            mem[(DATA_BASE + d) >> 2] = row_a[i];
            mem[(DATA_BASE + d + 4) >> 2] = row_b[i];
            foreach (w[k]) begin
                w[k] = NOP;
            end
            w[0] = enc_i(d, 5'd4, 3'b010, 5'd1, 7'b0000011);
            w[1] = enc_i(d + 4, 5'd4, 3'b010, 5'd2, 7'b0000011);
            w[11] = enc_s(r + 4, 5'd3, 3'b010);
            case (row_op[i])
                t_add:  w[5] = enc_r(7'h00, 3'b000);
                t_sub:  w[5] = enc_r(7'h20, 3'b000);
                t_sll:  w[5] = enc_r(7'h00, 3'b001);
                t_slt:  w[5] = enc_r(7'h00, 3'b010);
                t_sltu: w[5] = enc_r(7'h00, 3'b011);
                t_xor:  w[5] = enc_r(7'h00, 3'b100);
                t_srl:  w[5] = enc_r(7'h00, 3'b101);
                t_sra:  w[5] = enc_r(7'h20, 3'b101);
                t_or:   w[5] = enc_r(7'h00, 3'b110);
                t_and:  w[5] = enc_r(7'h00, 3'b111);
                t_addi: w[5] = enc_i(row_b[i][11:0], 5'd1, 3'b000, 5'd3, 7'b0010011);
                t_lui:  w[5] = {row_b[i][19:0], 5'd3, 7'b0110111};
                t_lb:   w[5] = enc_i(d + row_b[i][1:0], 5'd4, 3'b000, 5'd3, 7'b0000011);
                t_lbu:  w[5] = enc_i(d + row_b[i][1:0], 5'd4, 3'b100, 5'd3, 7'b0000011);
                t_beq, t_bne: begin
                    w[5] = enc_b(13'd16, (row_op[i] == t_bne) ? 3'b001 : 3'b000);
                    w[6] = enc_s(r, 5'd1, 3'b010);
                    w[9] = enc_s(r + 4, 5'd2, 3'b010);
                    w[11] = NOP;
                end
                t_jal: begin
                    w[5] = enc_jal(21'd16, 5'd3);
                    w[6] = enc_s(r, 5'd1, 3'b010);
                end
                default: begin
                    w[5] = enc_s(r, 5'd1, 3'b010);
                    w[6] = enc_s(r + row_b[i][9:8], 5'd2, 3'b000);
                    w[7] = enc_i(r, 5'd4, 3'b010, 5'd3, 7'b0000011);
                end
            endcase
            foreach (w[k]) begin
                mem[(base >> 2) + k] = w[k];
            end
            // store stream this row should produce, in order
            if (row_op[i] == t_beq || row_op[i] == t_bne) begin
                if (row_exp[i] == 0) begin
                    expect_store(DATA_BASE + r, 4'hf, row_a[i]);
                end
                expect_store(DATA_BASE + r + 4, 4'hf, row_b[i]);
            end else begin
                if (row_op[i] == t_sb) begin
                    expect_store(DATA_BASE + r, 4'hf, row_a[i]);
                    expect_store(DATA_BASE + r, 4'b0001 << row_b[i][9:8], {4{row_b[i][7:0]}});
                end
                expect_store(DATA_BASE + r + 4, 4'hf, row_exp[i]);
            end
        end
        // park the core in a self loop
        mem[(16 + NROWS * BLOCK * 4) >> 2] = enc_jal(21'd0, 5'd0);
    endtask

    task automatic check_store();
        logic [31:0] m;
        assert (exp_addr.size() > 0) else begin
            $display("store to %h at %0t with no store left to expect", mem_req.addr, $time);
            fail_now();
        end
        m = lane_bits(mem_req.mask);
        assert (mem_req.addr == exp_addr[0]) else begin
            $display("MISMATCH %0t mem_req.addr got %h expected %h",
                     $time, mem_req.addr, exp_addr[0]);
            fail_now();
        end
        assert (mem_req.mask == exp_mask[0]) else begin
            $display("MISMATCH %0t mem_req.mask got %h expected %h",
                     $time, mem_req.mask, exp_mask[0]);
            fail_now();
        end
        assert ((mem_req.wdata & m) == (exp_data[0] & m)) else begin
            $display("MISMATCH %0t mem_req.wdata got %h expected %h",
                     $time, mem_req.wdata & m, exp_data[0] & m);
            fail_now();
        end
        void'(exp_addr.pop_front());
        void'(exp_mask.pop_front());
        void'(exp_data.pop_front());
    endtask

    // memory model, answers one cycle after each accepted request
    always @(negedge clk) begin
        logic [31:0] word;
        logic [31:0] m;
        if (rst) begin
            assert (mem_req_valid == 1'b0) else begin
                $display("memory request raised during reset at %0t", $time);
                fail_now();
            end
        end else begin
            mem_rsp_valid = rsp_pending;
            mem_rsp_rdata = rsp_word;
            rsp_pending = 1'b0;
            mem_req_ready = (xorshift() % 4) != 0;
            if (mem_req_valid && mem_req_ready) begin
                if (!first_seen) begin
                    assert (mem_req.addr == `RV_RESET_PC && !mem_req.write) else begin
                        $display("first request after reset is not a fetch at the reset pc");
                        fail_now();
                    end
                    first_seen = 1'b1;
                end
                word = mem.exists(mem_req.addr >> 2) ? mem[mem_req.addr >> 2]
                                                      : mem_req.addr * 32'h9e37_79b1;
                if (mem_req.write) begin
                    check_store();
                    m = lane_bits(mem_req.mask);
                    mem[mem_req.addr >> 2] = (word & ~m) | (mem_req.wdata & m);
                end
                rsp_word = word;
                rsp_pending = 1'b1;
            end
        end
    end

    initial begin
        rst = 1'b1;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_rdata = '0;
        rsp_word = '0;
        fill_table();
        build_program();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (exp_addr.size() > 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > LIMIT) begin
                $display("timeout after %0d cycles with %0d stores missing",
                         cycles, exp_addr.size());
                fail_now();
            end
            verify_handshake();
        end
        // properties of the last edge have settled by now
        @(negedge clk);
        verify_handshake();
        $display("sim passed");
        $finish;
    end

endmodule
